/* cbus_golden.txt */
// Columns: port(a/b)_op(0 read, 1 write)_addr_wdata_byteen_bypass_expected
// Expected read data assumes memory cleared at reset, zero in write lines
a_1_01_11223344_f_0_00000000
a_0_01_00000000_f_0_11223344
b_1_21_a5a5a5a5_f_0_00000000
b_0_21_00000000_f_0_a5a5a5a5
a_1_02_cafef00d_f_0_00000000
a_1_02_12345678_5_0_00000000
a_0_02_00000000_f_0_ca34f078
a_1_03_0badc0de_f_1_00000000
a_1_03_89abcdef_6_1_00000000
a_0_03_00000000_f_1_89abcdef
a_1_04_deadbeef_f_0_00000000
b_1_22_0f0f0f0f_f_0_00000000
a_1_04_00aa00bb_a_0_00000000
b_1_23_13579bdf_f_0_00000000
a_0_04_00000000_f_0_00ad00ef
b_0_22_00000000_f_0_0f0f0f0f
a_0_01_00000000_f_0_11223344
b_0_21_00000000_f_0_a5a5a5a5
b_0_23_00000000_f_0_13579bdf
a_0_01_00000000_f_0_11223344
a_0_02_00000000_f_0_ca34f078
a_0_03_00000000_f_0_89abcdef
a_0_04_00000000_f_0_00ad00ef
a_0_01_00000000_f_0_11223344
a_0_02_00000000_f_0_ca34f078
a_1_05_ffeeddcc_3_0_00000000
a_0_05_00000000_f_0_0000ddcc

/* sources.f */
+incdir+.
cbus_pkg.sv
word_if.sv
rmw_converter.sv
word_arbiter.sv
word_memory.sv
cbus_top.sv
tb_top.sv

/* Bender.yml */
package:
  name: cbus_rmw

sources:
  - include_dirs:
      - .
    files:
      - cbus_pkg.sv
      - word_if.sv
      - rmw_converter.sv
      - word_arbiter.sv
      - word_memory.sv
      - cbus_top.sv
      - target: test
        files:
          - tb_top.sv

/* tb_top.sv */
// Testbench for the word memory subsystem
// Replays the golden transaction list on both ports and checks read data in order
`timescale 1ns/1ps

module tb_top
  import cbus_pkg::*;
();

  localparam int          MAX_LINES       = 64;
  localparam int          CYCLES_PER_LINE = 200;
  localparam logic [31:0] STALL_SEED      = 32'h4680_ea9d;

  logic         clk;
  logic         rst_n;
  logic         bypass;
  logic         a_cmd_valid;
  cbus_op_e     a_cmd_op;
  cbus_addr_t   a_cmd_addr;
  cbus_data_t   a_cmd_wdata;
  cbus_byteen_t a_cmd_byteen;
  logic         a_cmd_accept;
  logic         a_rsp_valid;
  cbus_data_t   a_rsp_rdata;
  logic         a_rsp_accept;
  logic         b_cmd_valid;
  cbus_op_e     b_cmd_op;
  cbus_addr_t   b_cmd_addr;
  cbus_data_t   b_cmd_wdata;
  logic         b_cmd_accept;
  logic         b_rsp_valid;
  cbus_data_t   b_rsp_rdata;
  logic         b_rsp_accept;

  // Port, op, addr, wdata, byteen, bypass and expected data, one nibble group each
  logic [87:0]  golden_mem [MAX_LINES];
  int           n_lines;
  cbus_data_t   exp_a [$];
  cbus_data_t   exp_b [$];

  cbus_top dut (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_bypass       (bypass),
    .i_a_cmd_valid  (a_cmd_valid),
    .i_a_cmd_op     (a_cmd_op),
    .i_a_cmd_addr   (a_cmd_addr),
    .i_a_cmd_wdata  (a_cmd_wdata),
    .i_a_cmd_byteen (a_cmd_byteen),
    .o_a_cmd_accept (a_cmd_accept),
    .o_a_rsp_valid  (a_rsp_valid),
    .o_a_rsp_rdata  (a_rsp_rdata),
    .i_a_rsp_accept (a_rsp_accept),
    .i_b_cmd_valid  (b_cmd_valid),
    .i_b_cmd_op     (b_cmd_op),
    .i_b_cmd_addr   (b_cmd_addr),
    .i_b_cmd_wdata  (b_cmd_wdata),
    .o_b_cmd_accept (b_cmd_accept),
    .o_b_rsp_valid  (b_rsp_valid),
    .o_b_rsp_rdata  (b_rsp_rdata),
    .i_b_rsp_accept (b_rsp_accept)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_rdata(input string port, input cbus_data_t expected,
                             input cbus_data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %0t port %s read data expected %h got %h",
                          $time, port, expected, actual));
    end
  endtask

  // Lines are presented in file order, each held until accepted
  task automatic drive_port_a();
    logic [87:0] line;
    for (int i = 0; i < n_lines; i++) begin
      line = golden_mem[i];
      if (line[87:84] == 4'ha) begin
        @(posedge clk);
        a_cmd_valid  <= 1'b1;
        a_cmd_op     <= cbus_op_e'(line[80]);
        a_cmd_addr   <= line[77:72];
        a_cmd_wdata  <= line[71:40];
        a_cmd_byteen <= line[39:36];
        bypass       <= line[32];
        if (line[80] == 1'b0) begin
          exp_a.push_back(line[31:0]);
        end
        do @(negedge clk); while (!a_cmd_accept);
      end
    end
    @(posedge clk);
    a_cmd_valid <= 1'b0;
  endtask

  task automatic drive_port_b();
    logic [87:0] line;
    for (int i = 0; i < n_lines; i++) begin
      line = golden_mem[i];
      if (line[87:84] == 4'hb) begin
        @(posedge clk);
        b_cmd_valid <= 1'b1;
        b_cmd_op    <= cbus_op_e'(line[80]);
        b_cmd_addr  <= line[77:72];
        b_cmd_wdata <= line[71:40];
        if (line[80] == 1'b0) begin
          exp_b.push_back(line[31:0]);
        end
        do @(negedge clk); while (!b_cmd_accept);
      end
    end
    @(posedge clk);
    b_cmd_valid <= 1'b0;
  endtask

  // --------------------
  // Responses
  // --------------------
  always @(negedge clk) begin
    if (rst_n && a_rsp_valid && a_rsp_accept) begin
      if (exp_a.size() == 0) begin
        abort_run("port A returned a read response with no read outstanding");
      end else begin
        check_rdata("A", exp_a.pop_front(), a_rsp_rdata);
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && b_rsp_valid && b_rsp_accept) begin
      if (exp_b.size() == 0) begin
        abort_run("port B returned a read response with no read outstanding");
      end else begin
        check_rdata("B", exp_b.pop_front(), b_rsp_rdata);
      end
    end
  end

  // Random response stalls on both ports, about one cycle in four
  initial begin : stall_gen
    void'($urandom(STALL_SEED));
    forever begin
      @(posedge clk);
      a_rsp_accept <= ($urandom % 4) != 0;
      b_rsp_accept <= ($urandom % 4) != 0;
    end
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if ((n_lines > 0) && (cycle_cnt >= n_lines * CYCLES_PER_LINE)) begin
        abort_run($sformatf("timeout: run did not finish within %0d cycles", cycle_cnt));
      end
    end
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin : main_flow
    rst_n        = 1'b0;
    bypass       = 1'b0;
    a_cmd_valid  = 1'b0;
    a_cmd_op     = CBUS_READ;
    a_cmd_addr   = '0;
    a_cmd_wdata  = '0;
    a_cmd_byteen = '0;
    a_rsp_accept = 1'b0;
    b_cmd_valid  = 1'b0;
    b_cmd_op     = CBUS_READ;
    b_cmd_addr   = '0;
    b_cmd_wdata  = '0;
    b_rsp_accept = 1'b0;
    n_lines      = 0;

    for (int i = 0; i < MAX_LINES; i++) begin
      golden_mem[i] = '0;
    end
    $readmemh("cbus_golden.txt", golden_mem);
    while ((n_lines < MAX_LINES) && ((golden_mem[n_lines][87:84] == 4'ha) ||
           (golden_mem[n_lines][87:84] == 4'hb))) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      abort_run("golden file could not be read or holds no transactions");
    end

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    fork
      drive_port_a();
      drive_port_b();
    join

    // Every read issued must come back before the run ends
    while ((exp_a.size() != 0) || (exp_b.size() != 0)) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* cbus_top.sv */
// Memory subsystem top level
// Port A through the RMW converter, port B direct, both arbitrated
// onto one word memory
`timescale 1ns/1ps

module cbus_top
  import cbus_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_bypass,
  // Port A, byte enabled
  input  logic         i_a_cmd_valid,
  input  cbus_op_e     i_a_cmd_op,
  input  cbus_addr_t   i_a_cmd_addr,
  input  cbus_data_t   i_a_cmd_wdata,
  input  cbus_byteen_t i_a_cmd_byteen,
  output logic         o_a_cmd_accept,
  output logic         o_a_rsp_valid,
  output cbus_data_t   o_a_rsp_rdata,
  input  logic         i_a_rsp_accept,
  // Port B, whole word
  input  logic         i_b_cmd_valid,
  input  cbus_op_e     i_b_cmd_op,
  input  cbus_addr_t   i_b_cmd_addr,
  input  cbus_data_t   i_b_cmd_wdata,
  output logic         o_b_cmd_accept,
  output logic         o_b_rsp_valid,
  output cbus_data_t   o_b_rsp_rdata,
  input  logic         i_b_rsp_accept
);

  word_if conv_bus ();
  word_if portb_bus ();
  word_if mem_bus ();

  // Port B pins onto its channel
  assign portb_bus.req_valid  = i_b_cmd_valid;
  assign portb_bus.req_op     = i_b_cmd_op;
  assign portb_bus.req_addr   = i_b_cmd_addr;
  assign portb_bus.req_wdata  = i_b_cmd_wdata;
  assign portb_bus.rsp_accept = i_b_rsp_accept;
  assign o_b_cmd_accept       = portb_bus.req_accept;
  assign o_b_rsp_valid        = portb_bus.rsp_valid;
  assign o_b_rsp_rdata        = portb_bus.rsp_rdata;

  rmw_converter u_rmw_converter (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_bypass     (i_bypass),
    .i_cmd_valid  (i_a_cmd_valid),
    .i_cmd_op     (i_a_cmd_op),
    .i_cmd_addr   (i_a_cmd_addr),
    .i_cmd_wdata  (i_a_cmd_wdata),
    .i_cmd_byteen (i_a_cmd_byteen),
    .o_cmd_accept (o_a_cmd_accept),
    .o_rsp_valid  (o_a_rsp_valid),
    .o_rsp_rdata  (o_a_rsp_rdata),
    .i_rsp_accept (i_a_rsp_accept),
    .mem_port     (conv_bus)
  );

  word_arbiter u_word_arbiter (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .req0    (conv_bus),
    .req1    (portb_bus),
    .mem     (mem_bus)
  );

  word_memory u_word_memory (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .bus     (mem_bus)
  );

endmodule

/* word_memory.sv */
// Single-port whole-word memory
// Registered read response, held under back-pressure
`timescale 1ns/1ps
`include "cbus_cfg.svh"

module word_memory
  import cbus_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  word_if.slave bus
);

  cbus_data_t mem_q [`CBUS_MEM_WORDS];
  cbus_data_t rdata_q;
  logic       rsp_valid_q;
  logic       take;

  // Room when the response register is empty or draining
  assign bus.req_accept = !rsp_valid_q || bus.rsp_accept;
  assign take           = bus.req_valid && bus.req_accept;
  assign bus.rsp_valid  = rsp_valid_q;
  assign bus.rsp_rdata  = rdata_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CBUS_MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (take && (bus.req_op == CBUS_WRITE)) begin
      mem_q[bus.req_addr] <= bus.req_wdata;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid_q <= 1'b0;
    end else if (take && (bus.req_op == CBUS_READ)) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_accept) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (take && (bus.req_op == CBUS_READ)) begin
      rdata_q <= mem_q[bus.req_addr];
    end
  end

endmodule

/* word_arbiter.sv */
// Round-robin arbiter of two word masters onto one memory
// Order queue routes read responses back to their requester
`timescale 1ns/1ps
`include "cbus_cfg.svh"

module word_arbiter
  import cbus_pkg::*;
(
  input  logic   i_clk,
  input  logic   i_rst_n,
  word_if.slave  req0,
  word_if.slave  req1,
  word_if.master mem
);

  localparam int DEPTH = `CBUS_ORDER_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic             last_gnt_q;
  logic             q_full;
  logic             elig0;
  logic             elig1;
  logic             gnt0;
  logic             gnt1;
  logic             push;
  logic             pop;
  logic             head;
  logic             order_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] q_cnt_q;

  // --------------------
  // Grant
  // --------------------
  // Reads wait while the order queue is full
  assign q_full = q_cnt_q == CNT_W'(DEPTH);
  assign elig0  = req0.req_valid && !((req0.req_op == CBUS_READ) && q_full);
  assign elig1  = req1.req_valid && !((req1.req_op == CBUS_READ) && q_full);
  assign gnt0   = elig0 && (!elig1 || last_gnt_q);
  assign gnt1   = elig1 && !gnt0;

  assign mem.req_valid = gnt0 || gnt1;
  assign mem.req_op    = gnt1 ? req1.req_op    : req0.req_op;
  assign mem.req_addr  = gnt1 ? req1.req_addr  : req0.req_addr;
  assign mem.req_wdata = gnt1 ? req1.req_wdata : req0.req_wdata;

  assign req0.req_accept = gnt0 && mem.req_accept;
  assign req1.req_accept = gnt1 && mem.req_accept;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_gnt_q <= 1'b1;
    end else if (mem.req_valid && mem.req_accept) begin
      last_gnt_q <= gnt1;
    end
  end

  // --------------------
  // Response routing
  // --------------------
  assign head = order_q[rd_ptr_q];
  assign push = mem.req_valid && mem.req_accept && (mem.req_op == CBUS_READ);
  assign pop  = mem.rsp_valid && mem.rsp_accept;

  assign req0.rsp_valid = mem.rsp_valid && !head;
  assign req1.rsp_valid = mem.rsp_valid && head;
  assign req0.rsp_rdata = mem.rsp_rdata;
  assign req1.rsp_rdata = mem.rsp_rdata;
  assign mem.rsp_accept = head ? req1.rsp_accept : req0.rsp_accept;

  always_ff @(posedge i_clk) begin
    if (push) begin
      order_q[wr_ptr_q] <= gnt1;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      q_cnt_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (pop)  rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      if (push && !pop) begin
        q_cnt_q <= q_cnt_q + CNT_W'(1);
      end else if (!push && pop) begin
        q_cnt_q <= q_cnt_q - CNT_W'(1);
      end
    end
  end

endmodule

/* rmw_converter.sv */
// Port A read-modify-write converter
// Full writes and reads pass through, partial writes become
// a read, a byte merge and a whole-word write
`timescale 1ns/1ps
`include "cbus_cfg.svh"

module rmw_converter
  import cbus_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_bypass,
  input  logic         i_cmd_valid,
  input  cbus_op_e     i_cmd_op,
  input  cbus_addr_t   i_cmd_addr,
  input  cbus_data_t   i_cmd_wdata,
  input  cbus_byteen_t i_cmd_byteen,
  output logic         o_cmd_accept,
  output logic         o_rsp_valid,
  output cbus_data_t   o_rsp_rdata,
  input  logic         i_rsp_accept,
  word_if.master       mem_port
);

  localparam int CNT_W = $clog2(`CBUS_MAX_OUTSTANDING + 1);

  typedef enum logic [1:0] {
    PASS_THROUGH,
    SEND_READ,
    WAIT_READ,
    WRITE_MERGED
  } rmw_state_e;

  rmw_state_e   state_q;
  logic [CNT_W-1:0] rd_cnt_q;
  logic         cnt_full;
  logic         cnt_zero;
  logic         cmd_partial;
  logic         partial_ack;
  logic         rd_issue;
  logic         rsp_done;
  cbus_addr_t   hold_addr_q;
  cbus_data_t   hold_data_q;
  cbus_byteen_t hold_be_q;

  // Enabled bytes from the new word, the rest from the old one
  function automatic cbus_data_t merge_bytes(
    cbus_data_t   new_word,
    cbus_byteen_t be,
    cbus_data_t   old_word
  );
    cbus_data_t mask;
    for (int i = 0; i < $bits(cbus_byteen_t); i++) begin
      mask[8*i+:8] = {8{be[i]}};
    end
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  // --------------------
  // Request side
  // --------------------
  always_comb begin
    cnt_full    = rd_cnt_q == CNT_W'(`CBUS_MAX_OUTSTANDING);
    cnt_zero    = rd_cnt_q == CNT_W'(0);
    cmd_partial = (i_cmd_op == CBUS_WRITE) && (i_cmd_byteen != '1) && !i_bypass;

    case (state_q)
      PASS_THROUGH: begin
        if (cmd_partial) begin
          // Captured locally, nothing goes to memory yet
          mem_port.req_valid = 1'b0;
          o_cmd_accept       = 1'b1;
        end else if (i_cmd_op == CBUS_READ) begin
          mem_port.req_valid = i_cmd_valid && !cnt_full;
          o_cmd_accept       = mem_port.req_accept && !cnt_full;
        end else begin
          mem_port.req_valid = i_cmd_valid;
          o_cmd_accept       = mem_port.req_accept;
        end
      end
      SEND_READ: begin
        mem_port.req_valid = cnt_zero;
        o_cmd_accept       = 1'b0;
      end
      WRITE_MERGED: begin
        mem_port.req_valid = 1'b1;
        o_cmd_accept       = 1'b0;
      end
      default: begin
        mem_port.req_valid = 1'b0;
        o_cmd_accept       = 1'b0;
      end
    endcase

    if (state_q == PASS_THROUGH) begin
      mem_port.req_op    = i_cmd_op;
      mem_port.req_addr  = i_cmd_addr;
      mem_port.req_wdata = i_cmd_wdata;
    end else begin
      mem_port.req_op    = (state_q == SEND_READ) ? CBUS_READ : CBUS_WRITE;
      mem_port.req_addr  = hold_addr_q;
      mem_port.req_wdata = hold_data_q;
    end
  end

  // --------------------
  // Response side
  // --------------------
  // Merge read is swallowed while waiting for it
  assign mem_port.rsp_accept = (state_q == WAIT_READ) ? 1'b1 : i_rsp_accept;
  assign o_rsp_valid         = (state_q != WAIT_READ) && mem_port.rsp_valid;
  assign o_rsp_rdata         = mem_port.rsp_rdata;

  assign partial_ack = (state_q == PASS_THROUGH) && i_cmd_valid && cmd_partial;
  assign rd_issue    = mem_port.req_valid && mem_port.req_accept &&
                       (mem_port.req_op == CBUS_READ);
  assign rsp_done    = mem_port.rsp_valid && mem_port.rsp_accept;

  // Held partial write, merged in place when the old word returns
  always_ff @(posedge i_clk) begin
    if (partial_ack) begin
      hold_addr_q <= i_cmd_addr;
      hold_data_q <= i_cmd_wdata;
      hold_be_q   <= i_cmd_byteen;
    end else if ((state_q == WAIT_READ) && mem_port.rsp_valid) begin
      hold_data_q <= merge_bytes(hold_data_q, hold_be_q, mem_port.rsp_rdata);
    end
  end

  // Reads in flight below the converter
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_cnt_q <= '0;
    end else if (rd_issue && !rsp_done) begin
      rd_cnt_q <= rd_cnt_q + CNT_W'(1);
    end else if (!rd_issue && rsp_done) begin
      rd_cnt_q <= rd_cnt_q - CNT_W'(1);
    end
  end

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= PASS_THROUGH;
    end else if (i_bypass) begin
      state_q <= PASS_THROUGH;
    end else begin
      case (state_q)
        PASS_THROUGH: if (partial_ack) state_q <= SEND_READ;
        SEND_READ:    if (mem_port.req_valid && mem_port.req_accept) state_q <= WAIT_READ;
        WAIT_READ:    if (mem_port.rsp_valid) state_q <= WRITE_MERGED;
        WRITE_MERGED: if (mem_port.req_accept) state_q <= PASS_THROUGH;
        default:      state_q <= PASS_THROUGH;
      endcase
    end
  end

endmodule

/* word_if.sv */
// Whole-word request/response channel
// Valid/accept handshake on both request and response
`timescale 1ns/1ps

interface word_if
  import cbus_pkg::*;
();

  // Request channel
  logic       req_valid;
  logic       req_accept;
  cbus_op_e   req_op;
  cbus_addr_t req_addr;
  cbus_data_t req_wdata;

  // Read response channel
  logic       rsp_valid;
  logic       rsp_accept;
  cbus_data_t rsp_rdata;

  modport master (
    output req_valid, req_op, req_addr, req_wdata, rsp_accept,
    input  req_accept, rsp_valid, rsp_rdata
  );

  modport slave (
    input  req_valid, req_op, req_addr, req_wdata, rsp_accept,
    output req_accept, rsp_valid, rsp_rdata
  );

endinterface

/* cbus_pkg.sv */
// Shared types of the word memory subsystem
// Bus operation enum plus data, address and byte-enable types
`include "cbus_cfg.svh"

package cbus_pkg;

  // --------------------
  // Request operation
  // --------------------
  typedef enum logic {
    CBUS_READ,
    CBUS_WRITE
  } cbus_op_e;

  // --------------------
  // Payload types
  // --------------------
  typedef logic [`CBUS_DATA_W-1:0] cbus_data_t;
  typedef logic [`CBUS_ADDR_W-1:0] cbus_addr_t;

  // One bit per byte lane
  typedef logic [(`CBUS_DATA_W/8)-1:0] cbus_byteen_t;

endpackage

/* cbus_cfg.svh */
// Configuration macros for the word memory subsystem
// Sizes of data and address, memory depth and queue limits
`ifndef CBUS_CFG_SVH
`define CBUS_CFG_SVH

// Data word width in bits
`define CBUS_DATA_W 32

// Word address width and memory depth
`define CBUS_ADDR_W 6
`define CBUS_MEM_WORDS 64

// Port A reads in flight through the converter
`define CBUS_MAX_OUTSTANDING 4

// Arbiter response-order queue entries
`define CBUS_ORDER_DEPTH 4

`endif
